//--- Makefile
TOP = tb_sys_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f sys_core.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- hdl/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
	input  logic                              clk_sys,
	input  logic [sys_core_pkg::att_w-1:0]    i_att,
	input  sys_core_pkg::mix_mode_e           i_mix,
	input  logic                              i_is_signed,
	input  logic [sys_core_pkg::audio_w-1:0]  i_core_audio,
	input  logic [sys_core_pkg::audio_w-1:0]  i_linux_audio,
	input  logic [sys_core_pkg::audio_w-1:0]  i_pre_in,
	output logic [sys_core_pkg::audio_w-1:0]  o_pre_out,
	output logic [sys_core_pkg::audio_w-1:0]  o_out
);
	import sys_core_pkg::*;

	logic        [audio_w-1:0] d1;
	logic        [audio_w-1:0] d2;
	logic signed [audio_w:0]   ca;
	logic signed [audio_w:0]   sum;
	logic signed [audio_w:0]   pre;
	logic signed [audio_w:0]   mixed;
	logic signed [audio_w:0]   att_out;

	// Neighbour channel, sign extended
	assign pre = {i_pre_in[audio_w-1], i_pre_in};

	////////////////////////////////////////////////////////////////////////////
	// Deglitch and sign handling
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		d1 <= i_core_audio;
		d2 <= d1;
		if (d1 == d2) begin
			if (i_is_signed)
				ca <= {d1[audio_w-1], d1};
			else
				ca <= {2'b00, d1[audio_w-1:1]};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sum, crossfeed, attenuation
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		sum <= ca + {i_linux_audio[audio_w-1], i_linux_audio};

		// Half level sent to the other channel
		o_pre_out <= sum[audio_w:1];

		case (i_mix)
			mix_none: mixed <= sum;
			mix_25:   mixed <= sum - (sum >>> 3) + (pre >>> 2);
			mix_50:   mixed <= sum - (sum >>> 2) + (pre >>> 1);
			mix_mono: mixed <= (sum >>> 1) + pre;
			default:  mixed <= sum;
		endcase

		if (i_att[att_w-1])
			att_out <= '0;
		else
			att_out <= mixed >>> i_att[att_w-2:0];

		// Saturate to 16 signed bits
		if (att_out[audio_w] ^ att_out[audio_w-1])
			o_out <= {att_out[audio_w], {(audio_w-1){att_out[audio_w-1]}}};
		else
			o_out <= att_out[audio_w-1:0];
	end

	// Mute reaches the output two stages later
	a_mute: assert property (@(posedge clk_sys)
		i_att[att_w-1] |-> ##2 (o_out == '0));

endmodule

//--- hdl/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
	input  logic                            clk_sys,
	input  logic                            resetd,
	host_io_if.decoder                      bus,
	output logic [7:0]                      o_led_overtake,
	output logic [7:0]                      o_led_state,
	output logic [sys_core_pkg::att_w-1:0]  o_vol_att
);
	import sys_core_pkg::*;

	host_word_u word;
	logic       has_cmd;
	logic [7:0] cmd;

	assign word = bus.din;

	////////////////////////////////////////////////////////////////////////////
	// Command sequence
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd        <= 1'b0;
			cmd            <= '0;
			o_led_overtake <= '0;
			o_led_state    <= '0;
			o_vol_att      <= '0;
		end else if (!bus.uio) begin
			// Idle, a partial command is dropped
			has_cmd <= 1'b0;
		end else if (bus.strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= bus.din[7:0];
			end else begin
				case (cmd)
					cmd_led: begin
						o_led_overtake <= word.led.overtake;
						o_led_state    <= word.led.state;
					end
					cmd_vol: begin
						o_vol_att <= word.vol.att;
					end
					// Other commands belong to blocks not in this design
					default: begin
					end
				endcase
			end
		end
	end

	a_reg_hold: assert property (@(posedge clk_sys) disable iff (resetd)
		!bus.strobe |=> $stable({o_led_overtake, o_led_state, o_vol_att}));

endmodule

//--- hdl/host_io_if.sv
`timescale 1ns/1ps

interface host_io_if;
	import sys_core_pkg::*;

	// One cycle pulse per host word
	logic                   strobe;
	// High while a command sequence is open
	logic                   uio;
	logic [host_word_w-1:0] din;
	// Core hold-off for the acknowledge
	logic                   io_wait;

	modport port (
		output strobe,
		output uio,
		output din,
		input  io_wait
	);

	modport decoder (
		input strobe,
		input uio,
		input din
	);

endinterface

//--- hdl/host_io_port.sv
`timescale 1ns/1ps

module host_io_port (
	input  logic                                  i_clk_sys,
	input  logic                                  i_resetd,
	input  logic                                  i_io_clk,
	input  logic                                  i_io_uio,
	input  logic [sys_core_pkg::host_word_w-1:0]  i_io_din,
	host_io_if.port                               bus,
	output logic                                  o_io_ack
);
	import sys_core_pkg::*;

	logic                   clk_s1;
	logic                   clk_s2;
	logic                   uio_s1;
	logic                   uio_s2;
	logic [host_word_w-1:0] din_s1;
	logic [host_word_w-1:0] din_s2;
	logic                   strobe_r;
	logic                   rack;
	logic                   word_pend;

	// New clock level not yet acknowledged
	assign word_pend = clk_s2 ^ rack;

	// Data is held by the host until ack, two stages are enough
	always_ff @(posedge i_clk_sys) begin
		din_s1 <= i_io_din;
		din_s2 <= din_s1;
	end

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			clk_s1   <= 1'b0;
			clk_s2   <= 1'b0;
			uio_s1   <= 1'b0;
			uio_s2   <= 1'b0;
			strobe_r <= 1'b0;
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			clk_s1   <= i_io_clk;
			clk_s2   <= clk_s1;
			uio_s1   <= i_io_uio;
			uio_s2   <= uio_s1;
			strobe_r <= word_pend & ~strobe_r;
			// Wait freezes rack, except on the strobe itself
			if (~bus.io_wait | strobe_r)
				rack <= clk_s2;
			o_io_ack <= rack;
		end
	end

	assign bus.strobe = strobe_r;
	assign bus.uio    = uio_s2;
	assign bus.din    = din_s2;

	// The strobe cycle takes the word even with wait high, so it never repeats
	a_strobe_single: assert property (@(posedge i_clk_sys) disable iff (i_resetd)
		bus.strobe |=> !word_pend);

endmodule

//--- hdl/led_panel.sv
`timescale 1ns/1ps

module led_panel (
	input  logic [1:0] i_led_power,
	input  logic [1:0] i_led_disk,
	input  logic       i_led_user,
	input  logic [7:0] i_led_overtake,
	input  logic [7:0] i_led_state,
	output logic       o_led_power,
	output logic       o_led_hdd,
	output logic       o_led_user,
	output logic [7:0] o_led
);

	logic [7:0] status;

	// Front LEDs are lit on a low level
	// Bit 1 selects forced mode, power is dark otherwise
	assign o_led_power = i_led_power[1] ? ~i_led_power[0] : 1'b1;

	// Forced and automatic modes light the disk LED the same way
	assign o_led_hdd = ~i_led_disk[0];

	assign o_led_user = ~i_led_user;

	// Board status byte
	assign status = {3'b000, ~o_led_power, 1'b0, ~o_led_hdd, 1'b0, ~o_led_user};

	// Host mask picks its own state bit per LED
	assign o_led = (i_led_overtake & i_led_state) | (~i_led_overtake & status);

endmodule

//--- hdl/sync_polarity_fix.sv
`timescale 1ns/1ps

module sync_polarity_fix #(
	parameter int CNT_W = 16
) (
	input  logic clk_sys,
	input  logic i_sync,
	output logic o_sync
);

	logic             s1;
	logic             s2;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;
	logic             pol;

	always_ff @(posedge clk_sys) begin
		s1 <= i_sync;
		s2 <= s1;

		// Rising edge closes a low run, falling edge a high run
		if (s1 & ~s2)
			low_len <= cnt;
		if (~s1 & s2)
			high_len <= cnt;

		if (s1 != s2) begin
			cnt <= '0;
		end else if (~&cnt) begin
			// Saturate on a stuck input
			cnt <= cnt + 1'b1;
		end

		pol <= high_len > low_len;
	end

	// Shorter part of the period comes out high
	assign o_sync = i_sync ^ pol;

endmodule

//--- hdl/sys_core.sv
`timescale 1ns/1ps

module sys_core (
	input  logic                                  clk_sys,
	input  logic                                  resetd,

	// Host port
	input  logic                                  i_io_clk,
	input  logic                                  i_io_uio,
	input  logic [sys_core_pkg::host_word_w-1:0]  i_io_din,
	input  logic                                  i_io_wait,
	output logic                                  o_io_ack,

	// LEDs
	input  logic [1:0]                            i_led_power,
	input  logic [1:0]                            i_led_disk,
	input  logic                                  i_led_user,
	output logic                                  o_led_power,
	output logic                                  o_led_hdd,
	output logic                                  o_led_user,
	output logic [7:0]                            o_led,

	// Video sync
	input  logic                                  i_hs,
	input  logic                                  i_vs,
	output logic                                  o_hs,
	output logic                                  o_vs,

	// Audio
	input  logic [sys_core_pkg::audio_w-1:0]      i_audio_l,
	input  logic [sys_core_pkg::audio_w-1:0]      i_audio_r,
	input  logic [sys_core_pkg::audio_w-1:0]      i_alsa_l,
	input  logic [sys_core_pkg::audio_w-1:0]      i_alsa_r,
	input  logic                                  i_audio_s,
	input  logic [1:0]                            i_audio_mix,
	output logic [sys_core_pkg::audio_w-1:0]      o_audio_l,
	output logic [sys_core_pkg::audio_w-1:0]      o_audio_r
);
	import sys_core_pkg::*;

	logic [7:0]       led_overtake;
	logic [7:0]       led_state;
	logic [att_w-1:0] vol_att;
	logic [audio_w-1:0] audio_l_pre;
	logic [audio_w-1:0] audio_r_pre;
	mix_mode_e        audio_mix;

	assign audio_mix = mix_mode_e'(i_audio_mix);

	////////////////////////////////////////////////////////////////////////////
	// Host interface and registers
	////////////////////////////////////////////////////////////////////////////

	host_io_if bus ();

	assign bus.io_wait = i_io_wait;

	host_io_port u_host_io_port (
		.i_clk_sys (clk_sys),
		.i_resetd  (resetd),
		.i_io_clk  (i_io_clk),
		.i_io_uio  (i_io_uio),
		.i_io_din  (i_io_din),
		.bus       (bus.port),
		.o_io_ack  (o_io_ack)
	);

	cmd_decoder u_cmd_decoder (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.bus            (bus.decoder),
		.o_led_overtake (led_overtake),
		.o_led_state    (led_state),
		.o_vol_att      (vol_att)
	);

	led_panel u_led_panel (
		.i_led_power    (i_led_power),
		.i_led_disk     (i_led_disk),
		.i_led_user     (i_led_user),
		.i_led_overtake (led_overtake),
		.i_led_state    (led_state),
		.o_led_power    (o_led_power),
		.o_led_hdd      (o_led_hdd),
		.o_led_user     (o_led_user),
		.o_led          (o_led)
	);

	// Counters must span a full frame for the vertical one
	sync_polarity_fix #(.CNT_W(16)) u_sync_h (
		.clk_sys (clk_sys),
		.i_sync  (i_hs),
		.o_sync  (o_hs)
	);

	sync_polarity_fix #(.CNT_W(16)) u_sync_v (
		.clk_sys (clk_sys),
		.i_sync  (i_vs),
		.o_sync  (o_vs)
	);

	////////////////////////////////////////////////////////////////////////////
	// Audio, each channel feeds its half level to the other
	////////////////////////////////////////////////////////////////////////////

	audio_mixer u_mix_l (
		.clk_sys       (clk_sys),
		.i_att         (vol_att),
		.i_mix         (audio_mix),
		.i_is_signed   (i_audio_s),
		.i_core_audio  (i_audio_l),
		.i_linux_audio (i_alsa_l),
		.i_pre_in      (audio_r_pre),
		.o_pre_out     (audio_l_pre),
		.o_out         (o_audio_l)
	);

	audio_mixer u_mix_r (
		.clk_sys       (clk_sys),
		.i_att         (vol_att),
		.i_mix         (audio_mix),
		.i_is_signed   (i_audio_s),
		.i_core_audio  (i_audio_r),
		.i_linux_audio (i_alsa_r),
		.i_pre_in      (audio_l_pre),
		.o_pre_out     (audio_r_pre),
		.o_out         (o_audio_r)
	);

endmodule

//--- hdl/sys_core_pkg.sv
package sys_core_pkg;

	// Word widths
	localparam int host_word_w = 16;
	localparam int audio_w     = 16;

	// Top bit of the attenuation code mutes the channel
	localparam int att_w = 5;

	// Host command codes
	localparam logic [7:0] cmd_led = 8'h25;
	localparam logic [7:0] cmd_vol = 8'h26;

	// LED command data, mask in the upper byte
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_word_t;

	// Volume command data, only the low bits carry the code
	typedef struct packed {
		logic [host_word_w-att_w-1:0] unused;
		logic [att_w-1:0]             att;
	} vol_word_t;

	// One host data word, decoded by the current command
	typedef union packed {
		led_word_t led;
		vol_word_t vol;
	} host_word_u;

	// Stereo crossfeed amount
	typedef enum logic [1:0] {
		mix_none = 2'd0,
		mix_25   = 2'd1,
		mix_50   = 2'd2,
		mix_mono = 2'd3
	} mix_mode_e;

endpackage

//--- sys_core.f
hdl/sys_core_pkg.sv
hdl/host_io_if.sv
hdl/host_io_port.sv
hdl/cmd_decoder.sv
hdl/led_panel.sv
hdl/sync_polarity_fix.sv
hdl/audio_mixer.sv
hdl/sys_core.sv
test/tb_sys_core.sv

//--- test/tb_sys_core.sv
`timescale 1ns/1ps

module tb_sys_core;
	import sys_core_pkg::*;

	logic                   clk_sys;
	logic                   resetd;
	logic                   i_io_clk;
	logic                   i_io_uio;
	logic [host_word_w-1:0] i_io_din;
	logic                   i_io_wait;
	logic                   o_io_ack;
	logic [1:0]             i_led_power;
	logic [1:0]             i_led_disk;
	logic                   i_led_user;
	logic                   o_led_power;
	logic                   o_led_hdd;
	logic                   o_led_user;
	logic [7:0]             o_led;
	logic                   i_hs;
	logic                   i_vs;
	logic                   o_hs;
	logic                   o_vs;
	logic [audio_w-1:0]     i_audio_l;
	logic [audio_w-1:0]     i_audio_r;
	logic [audio_w-1:0]     i_alsa_l;
	logic [audio_w-1:0]     i_alsa_r;
	logic                   i_audio_s;
	logic [1:0]             i_audio_mix;
	logic [audio_w-1:0]     o_audio_l;
	logic [audio_w-1:0]     o_audio_r;

	// Reference model state
	logic [31:0]            seed;
	logic [7:0]             m_cmd;
	logic [7:0]             m_overtake;
	logic [7:0]             m_state;
	logic [att_w-1:0]       m_att;
	logic [31:0]            r;

	sys_core dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Inputs change 10 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#10;
	endtask

	// One host word, toggles the host clock and waits for the ack
	task automatic send_word(input logic uio, input logic [host_word_w-1:0] data);
		int   n;
		logic lvl;
		lvl      = ~i_io_clk;
		i_io_uio = uio;
		i_io_din = data;
		i_io_clk = lvl;
		n = 0;
		while (o_io_ack !== lvl && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		assert (o_io_ack === lvl) else begin
			$display("timeout: o_io_ack did not follow the host clock within 20 cycles");
			abort_run();
		end
		tick();
	endtask

	// Data word for the open command
	task automatic send_data(input logic [host_word_w-1:0] data);
		send_word(1'b1, data);
		if (m_cmd == cmd_led) begin
			m_overtake = data[15:8];
			m_state    = data[7:0];
		end else if (m_cmd == cmd_vol) begin
			m_att = data[att_w-1:0];
		end
	endtask

	task automatic send_cmd(input logic [7:0] cmd, input logic [host_word_w-1:0] data);
		// Close any open sequence, two sync stages plus margin
		i_io_uio = 1'b0;
		repeat (4) tick();
		send_word(1'b1, {8'h00, cmd});
		m_cmd = cmd;
		send_data(data);
	endtask

	task automatic check_leds();
		logic [31:0] rnd;
		logic        pwr_lit;
		logic        hdd_lit;
		logic        user_lit;
		logic        pwr_lvl;
		logic        hdd_lvl;
		logic        user_lvl;
		logic [7:0]  status;
		logic [7:0]  exp_led;
		rnd = next_rand();
		i_led_power = rnd[31:30];
		i_led_disk  = rnd[29:28];
		i_led_user  = rnd[27];
		// Forced power shows bit 0 and stays dark otherwise
		pwr_lit  = i_led_power[1] & i_led_power[0];
		hdd_lit  = i_led_disk[0];
		user_lit = i_led_user;
		// Front pins are driven low to light
		pwr_lvl  = !pwr_lit;
		hdd_lvl  = !hdd_lit;
		user_lvl = !user_lit;
		status    = 8'h00;
		status[4] = pwr_lit;
		status[2] = hdd_lit;
		status[0] = user_lit;
		for (int b = 0; b < 8; b++)
			exp_led[b] = m_overtake[b] ? m_state[b] : status[b];
		@(negedge clk_sys);
		check_val("o_led_power", o_led_power, pwr_lvl);
		check_val("o_led_hdd", o_led_hdd, hdd_lvl);
		check_val("o_led_user", o_led_user, user_lvl);
		check_val("o_led", o_led, exp_led);
		tick();
	endtask

	// Core plus Linux sample, unsigned core audio at half scale
	function automatic int sum_of(input logic [15:0] core, input logic [15:0] linux,
			input logic is_signed);
		int c;
		if (is_signed)
			c = $signed(core);
		else
			c = core >> 1;
		return c + $signed(linux);
	endfunction

	// Halving steps are arithmetic shifts
	function automatic logic [15:0] mix_out(input int own, input int other,
			input logic [1:0] mode, input logic [att_w-1:0] att);
		int pre;
		int m;
		pre = other >>> 1;
		case (mode)
			2'd0: m = own;
			2'd1: m = own - (own >>> 3) + (pre >>> 2);
			2'd2: m = own - (own >>> 2) + (pre >>> 1);
			default: m = (own >>> 1) + pre;
		endcase
		if (att[att_w-1])
			m = 0;
		else
			m = m >>> att[att_w-2:0];
		if (m > 32767)
			m = 32767;
		if (m < -32768)
			m = -32768;
		return m[15:0];
	endfunction

	task automatic check_audio();
		logic [31:0] rnd;
		int          sl;
		int          sr;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		rnd = next_rand();
		i_audio_l = rnd[31:16];
		i_audio_r = rnd[15:0];
		rnd = next_rand();
		i_alsa_l = rnd[31:16];
		i_alsa_r = rnd[15:0];
		rnd = next_rand();
		i_audio_s   = rnd[31];
		i_audio_mix = rnd[30:29];
		repeat (20) tick();
		sl = sum_of(i_audio_l, i_alsa_l, i_audio_s);
		sr = sum_of(i_audio_r, i_alsa_r, i_audio_s);
		exp_l = mix_out(sl, sr, i_audio_mix, m_att);
		exp_r = mix_out(sr, sl, i_audio_mix, m_att);
		check_val("o_audio_l", o_audio_l, exp_l);
		check_val("o_audio_r", o_audio_r, exp_r);
	endtask

	// Pulse is the short part of each period, polarity random
	task automatic check_sync();
		logic [31:0] rnd;
		int          h_pulse;
		int          h_per;
		int          v_pulse;
		int          v_per;
		int          total;
		logic        h_pol;
		logic        v_pol;
		logic        exp_h;
		logic        exp_v;
		rnd = next_rand();
		h_pulse = 2 + rnd[31:27];
		h_per   = 2 * h_pulse + 4 + rnd[26:21];
		h_pol   = rnd[20];
		v_pulse = 2 + rnd[19:14];
		v_per   = 2 * v_pulse + 4 + rnd[13:7];
		v_pol   = rnd[6];
		total   = 4 * ((h_per > v_per) ? h_per : v_per);
		for (int k = 0; k < total; k++) begin
			i_hs = ((k % h_per) < h_pulse) ? h_pol : ~h_pol;
			i_vs = ((k % v_per) < v_pulse) ? v_pol : ~v_pol;
			exp_h = (i_hs == h_pol);
			exp_v = (i_vs == v_pol);
			@(negedge clk_sys);
			if (k >= 3 * h_per)
				check_val("o_hs", o_hs, exp_h);
			if (k >= 3 * v_per)
				check_val("o_vs", o_vs, exp_v);
			tick();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed        = 32'h7347_d1ef;
		resetd      = 1'b1;
		i_io_clk    = 1'b0;
		i_io_uio    = 1'b0;
		i_io_din    = '0;
		i_io_wait   = 1'b0;
		i_led_power = 2'b00;
		i_led_disk  = 2'b00;
		i_led_user  = 1'b0;
		i_hs        = 1'b0;
		i_vs        = 1'b0;
		i_audio_l   = '0;
		i_audio_r   = '0;
		i_alsa_l    = '0;
		i_alsa_r    = '0;
		i_audio_s   = 1'b1;
		i_audio_mix = 2'b00;
		m_cmd       = 8'h00;
		m_overtake  = 8'h00;
		m_state     = 8'h00;
		m_att       = '0;
		repeat (3) @(posedge clk_sys);
		#10;
		resetd = 1'b0;

		// Reset state, no overtake yet
		check_val("o_io_ack", o_io_ack, 32'd0);
		repeat (4) check_leds();

		// LED overtake, some sequences carry a second data word
		repeat (8) begin
			r = next_rand();
			send_cmd(cmd_led, r[31:16]);
			repeat (3) check_leds();
			if (r[0]) begin
				r = next_rand();
				send_data(r[31:16]);
				repeat (2) check_leds();
			end
		end

		// Attenuation, mute and crossfeed
		send_cmd(cmd_vol, 16'h0000);
		repeat (4) check_audio();
		repeat (10) begin
			r = next_rand();
			send_cmd(cmd_vol, r[31:16]);
			repeat (3) check_audio();
		end

		// Dropped sequence, next word opens a new command
		r = next_rand();
		send_cmd(cmd_led, r[31:16]);
		i_io_uio = 1'b0;
		repeat (4) tick();
		send_word(1'b1, {8'h00, cmd_vol});
		i_io_uio = 1'b0;
		repeat (4) tick();
		r = next_rand();
		send_word(1'b1, {r[31:24], cmd_led});
		m_cmd = cmd_led;
		repeat (2) check_leds();
		check_audio();
		send_data(r[15:0]);
		repeat (2) check_leds();

		// Wait held high across whole commands
		i_io_wait = 1'b1;
		r = next_rand();
		send_cmd(cmd_led, r[31:16]);
		check_leds();
		send_data(r[15:0]);
		check_leds();
		i_io_wait = 1'b0;
		repeat (6) begin
			r = next_rand();
			send_word(1'b0, r[31:16]);
		end
		check_leds();

		repeat (6) check_sync();

		$display("Verification passed");
		$finish;
	end

endmodule
